/* compile.f */
logic/cpu_pkg.sv
logic/cpu_decoder.sv
logic/cpu_sequencer.sv
logic/cpu_alu.sv
logic/cpu_datapath.sv
logic/cpu_core.sv
verif/tb_clock.sv
verif/cpu_tb.sv

/* Bender.yml */
package:
  name: cpu_core

sources:
  - logic/cpu_pkg.sv
  - logic/cpu_decoder.sv
  - logic/cpu_sequencer.sv
  - logic/cpu_alu.sv
  - logic/cpu_datapath.sv
  - logic/cpu_core.sv
  - target: test
    files:
      - verif/tb_clock.sv
      - verif/cpu_tb.sv

/* verif/cpu_tb.sv */
`timescale 1ns/1ps

module cpu_tb;

    localparam logic [15:0] vector_addr = 16'hfffc;
    localparam logic [15:0] code_start  = 16'h0400;

    logic        clock, reset, enable;
    logic [7:0]  data_in, data_out;
    logic [15:0] address;
    logic        write_enable, sync;
    logic [7:0]  mem [0:65535];             // Flat 64 KiB memory
    logic [15:0] pc_asm;                    // Assembly pointer
    logic [7:0]  ma, mx, my;                // Model registers
    logic        mn, mv, mz, mc;            // Model flags
    logic [31:0] seed = 32'd39;
    logic [15:0] exp_sync [$];              // Expected sync addresses
    int          exp_gap [$];               // Cycles until the next sync
    logic [15:0] exp_wr_addr [$];
    logic [7:0]  exp_wr_data [$];
    logic [7:0]  alu_ops [5] = '{8'h09, 8'h29, 8'h49, 8'h69, 8'he9}; // ORA AND EOR ADC SBC
    logic [15:0] want_addr;
    logic [7:0]  want_data, stall_draw;
    int          errors = 0, n_sync = 0, n_wr = 0;
    int          gap_count, prev_gap, boot = 0, stall_left = 0;
    bit          have_prev = 0, done = 0, stalls_on = 0;

    tb_clock clock_gen (.clock(clock), .reset(reset));

    cpu_core #(.reset_vector(vector_addr)) UUT (
        .clock(clock), .reset(reset), .enable(enable), .data_in(data_in),
        .address(address), .data_out(data_out), .write_enable(write_enable), .sync(sync)
    );

    assign data_in = mem[address]; // Combinational read

    always @(posedge clock)
        if (enable && write_enable)
            mem[address] <= data_out;

    function logic [7:0] next_random();
        seed = seed * 32'd1103515245 + 32'd12345; // LCG step
        return seed[23:16];
    endfunction

    task put_byte(input logic [7:0] b);
        mem[pc_asm] = b;
        pc_asm = pc_asm + 16'd1;
    endtask

    task begin_inst(input logic [7:0] opc, input int cycles);
        exp_sync.push_back(pc_asm);
        exp_gap.push_back(cycles);
        put_byte(opc);
    endtask

    task set_nz(input logic [7:0] v);
        mn = v[7];
        mz = (v == 8'h00);
    endtask

    task load_a(input logic [7:0] v);
        ma = v;
        set_nz(v);
    endtask

    task load_x(input logic [7:0] v);
        mx = v;
        set_nz(v);
    endtask

    task load_y(input logic [7:0] v);
        my = v;
        set_nz(v);
    endtask

    task add_model(input logic [7:0] v); // Binary add with v inverted by the caller for SBC
        logic [8:0] s;
        int         signed_sum;
        s = {1'b0, ma} + {1'b0, v} + {8'h00, mc};
        signed_sum = int'($signed(ma)) + int'($signed(v)) + int'(mc);
        mv = (signed_sum > 127) || (signed_sum < -128); // Outside the signed byte range
        mc = s[8];
        ma = s[7:0];
        set_nz(ma);
    endtask

    task compare_model(input logic [7:0] r, input logic [7:0] v);
        mc = (r >= v);             // No borrow
        set_nz(r - v);
    endtask

    // Instruction effect on registers and flags per the instruction set
    task run_model(input logic [7:0] opc, input logic [7:0] v);
        case (opc)
            8'h09, 8'h05, 8'h0d: load_a(ma | v);
            8'h29, 8'h25, 8'h2d: load_a(ma & v);
            8'h49, 8'h45, 8'h4d: load_a(ma ^ v);
            8'h69, 8'h65, 8'h6d: add_model(v);
            8'he9, 8'he5, 8'hed: add_model(~v);
            8'ha9, 8'ha5, 8'had: load_a(v);
            8'ha2, 8'ha6, 8'hae: load_x(v);
            8'ha0, 8'ha4, 8'hac: load_y(v);
            8'hc9, 8'hc5, 8'hcd: compare_model(ma, v);
            8'he0, 8'he4, 8'hec: compare_model(mx, v);
            8'hc0, 8'hc4, 8'hcc: compare_model(my, v);
            8'haa: load_x(ma); // TAX
            8'ha8: load_y(ma); // TAY
            8'h8a: load_a(mx); // TXA
            8'h98: load_a(my); // TYA
            8'he8: load_x(mx + 8'd1);
            8'hca: load_x(mx - 8'd1);
            8'hc8: load_y(my + 8'd1);
            8'h88: load_y(my - 8'd1);
            8'h18: mc = 1'b0;
            8'h38: mc = 1'b1;
            8'hb8: mv = 1'b0;
            default: ;
        endcase
    endtask

    task immediate(input logic [7:0] opc, input logic [7:0] v);
        begin_inst(opc, 2);
        put_byte(v);
        run_model(opc, v);
    endtask

    task implied(input logic [7:0] opc);
        begin_inst(opc, 2);
        run_model(opc, 8'h00);
    endtask

    task memory_op(input logic [7:0] opc, input logic [15:0] addr, input bit is_abs);
        begin_inst(opc, is_abs ? 4 : 3);
        put_byte(addr[7:0]);
        if (is_abs)
            put_byte(addr[15:8]);
        if (opc inside {8'h84, 8'h85, 8'h86, 8'h8c, 8'h8d, 8'h8e})
        begin
            exp_wr_addr.push_back(addr);
            exp_wr_data.push_back(opc[1] ? mx : (opc[0] ? ma : my)); // STX STA STY
        end
        else
            run_model(opc, mem[addr]);
    endtask

    task branch(input logic [7:0] opc, input logic [7:0] off, output bit taken);
        logic        flag;
        logic [15:0] next, target;
        case (opc[7:6])
            2'd0: flag = mn;
            2'd1: flag = mv;
            2'd2: flag = mc;
            default: flag = mz;
        endcase
        taken  = (flag == opc[5]);
        next   = pc_asm + 16'd2;
        target = next + {{8{off[7]}}, off};
        begin_inst(opc, !taken ? 2 : (target[15:8] == next[15:8] ? 3 : 4));
        put_byte(off);
        if (taken)
            pc_asm = target;
    endtask

    task branch_over_marker(input logic [7:0] opc); // Marker is STX $f0
        logic [15:0] p;
        bit          t;
        p = pc_asm;
        branch(opc, 8'h02, t);
        if (t)
        begin
            mem[p + 16'd2] = 8'h86; // Laid out but skipped
            mem[p + 16'd3] = 8'hf0;
        end
        else
            memory_op(8'h86, 16'h00f0, 1'b0);
    endtask

    task jump(input logic [15:0] target);
        begin_inst(8'h4c, 3);
        put_byte(target[7:0]);
        put_byte(target[15:8]);
        pc_asm = target;
    endtask

    // Frozen core keeps its bus still
    assert property (@(posedge clock) disable iff (reset)
                     !enable |=> $stable(address) && $stable(write_enable))
    else
    begin
        errors++;
        $display("Bus moved at %0t while enable was low", $time);
    end

    always @(posedge clock)
    begin
        if (reset)
        begin
            assert (!write_enable)
            else
            begin
                errors++;
                $display("Write during reset");
            end
        end
        else if (enable)
        begin
            if (boot < 2) // Vector bytes
            begin
                assert (address == vector_addr + boot[15:0])
                else
                begin
                    errors++;
                    $display("Error at %0t: address expected %h actual %h", $time,
                             vector_addr + boot[15:0], address);
                end
                boot++;
            end
            if (sync && !done)
            begin
                if (have_prev)
                    assert (gap_count == prev_gap)
                    else
                    begin
                        errors++;
                        $display("Error at %0t: sync spacing expected %0d actual %0d",
                                 $time, prev_gap, gap_count);
                    end
                want_addr = exp_sync.pop_front();
                assert (address == want_addr)
                else
                begin
                    errors++;
                    $display("Error at %0t: sync address expected %h actual %h",
                             $time, want_addr, address);
                end
                prev_gap  = exp_gap.pop_front();
                have_prev = 1;
                gap_count = 1;
                n_sync++;
                done = (exp_sync.size() == 0);
            end
            else
                gap_count++;
            if (write_enable)
            begin
                if (exp_wr_addr.size() == 0)
                begin
                    errors++;
                    $display("Unexpected write at %0t to %h", $time, address);
                end
                else
                begin
                    want_addr = exp_wr_addr.pop_front();
                    want_data = exp_wr_data.pop_front();
                    n_wr++;
                    assert (address == want_addr && data_out == want_data)
                    else
                    begin
                        errors++;
                        $display("Error at %0t: address/data_out expected %h/%h actual %h/%h",
                                 $time, want_addr, want_data, address, data_out);
                    end
                end
            end
        end
    end

    // Random stalls after the edge
    always @(posedge clock)
    begin
        #1;
        if (reset || !stalls_on)
            enable = 1'b1;
        else if (stall_left > 0)
        begin
            enable = 1'b0;
            stall_left--;
        end
        else
        begin
            stall_draw = next_random();
            enable = 1'b1;
            if (stall_draw[2:0] == 3'd0)
                stall_left = stall_draw[5:4] + 1; // Stretch of 1 to 4 cycles
        end
    end

    initial
    begin
        logic [7:0]  r;
        logic [7:0]  s;
        logic [7:0]  ld_ops [9];
        logic [7:0]  st_ops [6];
        bit          t;
        int          k;
        longint      limit;
        enable = 1'b1;
        for (int i = 0; i < 65536; i++)
            mem[i] = i[7:0] ^ i[15:8] ^ 8'h5a;   // Address-derived background
        mem[vector_addr]         = code_start[7:0];
        mem[vector_addr + 16'd1] = code_start[15:8];
        {ma, mx, my} = '0;
        {mn, mv, mz, mc} = 4'b0000;            // Flags clear after reset
        pc_asm = code_start;
        ld_ops = '{8'ha9, 8'ha5, 8'had, 8'ha2, 8'ha6, 8'hae, 8'ha0, 8'ha4, 8'hac};
        st_ops = '{8'h85, 8'h8d, 8'h86, 8'h8e, 8'h84, 8'h8c};
        k = 0;
        for (int g = 0; g < 3; g++)              // A, X, Y
            for (int f = 0; f < 3; f++)          // Immediate, zero page, absolute
            begin
                if (f == 0)
                    immediate(ld_ops[3*g], next_random());
                else
                    memory_op(ld_ops[3*g+f], f == 1 ? 16'h0010 + k : 16'h0300 + k, f == 2);
                memory_op(st_ops[2*g+k%2], k % 2 ? 16'h0200 + k : 16'h0080 + k, k % 2);
                k++;
            end
        for (int i = 0; i < 40; i++)             // ALU with flag checks
        begin
            r = next_random();
            immediate(8'ha9, next_random());
            implied(r[0] ? 8'h38 : 8'h18);
            immediate(alu_ops[r[7:5] % 5], next_random());
            memory_op(8'h8d, 16'h0220 + i, 1'b1);
            branch_over_marker(8'hb0);           // BCS
            branch_over_marker(8'hf0);           // BEQ
            branch_over_marker(8'h70);           // BVS
        end
        for (int i = 0; i < 8; i++)              // Compares and transfers
        begin
            r = next_random();
            s = (i % 3 == 0) ? r : next_random();
            immediate(8'ha9, r);
            immediate(8'hc9, s);
            branch_over_marker(8'hf0);
            branch_over_marker(8'h90);           // BCC
            immediate(8'ha2, s);
            immediate(8'he0, r);
            branch_over_marker(8'hf0);
            immediate(8'ha0, r);
            immediate(8'hc0, s);
            branch_over_marker(8'h90);
            implied(8'haa);
            implied(8'he8);
            memory_op(8'h86, 16'h0090, 1'b0);
            implied(8'ha8);
            memory_op(8'h84, 16'h0091, 1'b0);
            implied(8'hca);
            implied(8'h8a);
            memory_op(8'h85, 16'h0092, 1'b0);
            implied(8'h98);
            memory_op(8'h8d, 16'h0280, 1'b1);
        end
        implied(8'h18);
        branch(8'hb0, 8'h05, t);                 // BCS not taken
        implied(8'h38);
        branch_over_marker(8'hb0);               // Taken in page
        jump(16'h0efb);
        implied(8'h18);
        branch(8'h90, 8'h10, t);                 // Crosses into page 0f
        jump(pc_asm);                            // Parks the core
        limit = (longint'(exp_sync.size()) * 20 + 10) * 8;
        wait (!reset);
        @(posedge clock);
        stalls_on = 1;
        fork
            wait (done);
            begin
                #(limit);
                $display("Watchdog expired before the program finished");
                $display("TB FAILED");
                $finish;
            end
        join_any
        disable fork;
        assert (exp_wr_addr.size() == 0)
        else
        begin
            errors++;
            $display("%0d expected writes never happened", exp_wr_addr.size());
        end
        $display("Summary: %0d errors, %0d syncs and %0d writes checked", errors, n_sync, n_wr);
        if (errors == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

endmodule

/* verif/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock
#(
    parameter int half_period = 4,  // 8 ns clock
    parameter int reset_cycles = 10
)
(
    output logic clock,
    output logic reset
);

    initial
    begin
        clock = 1'b0;
        forever #(half_period) clock = ~clock;
    end

    initial
    begin
        reset = 1'b1;
        repeat (reset_cycles) @(posedge clock);
        #1 reset = 1'b0; // Released just after an edge like every other input
    end

endmodule

/* logic/cpu_core.sv */
`timescale 1ns/1ps

module cpu_core import cpu_pkg::*;
#(
    parameter logic [word_w-1:0] reset_vector = 16'hfffc
)
(
    input  logic              clock,
    input  logic              reset,
    input  logic              enable,
    input  logic [byte_w-1:0] data_in,
    output logic [word_w-1:0] address,
    output logic [byte_w-1:0] data_out,
    output logic              write_enable,
    output logic              sync
);

    control_t          control;
    status_t           status;
    logic [byte_w-1:0] data_in_latched;
    logic              branch_cross;

    // Cycle FSM and opcode decode
    cpu_sequencer sequencer (
        .clock           (clock),
        .reset           (reset),
        .enable          (enable),
        .data_in         (data_in),
        .status          (status),
        .data_in_latched (data_in_latched),
        .branch_cross    (branch_cross),
        .control         (control),
        .sync            (sync)
    );

    // Registers, ALU and bus muxing
    cpu_datapath #(
        .reset_vector (reset_vector)
    ) datapath (
        .clock           (clock),
        .reset           (reset),
        .enable          (enable),
        .data_in         (data_in),
        .control         (control),
        .address         (address),
        .data_out        (data_out),
        .write_enable    (write_enable),
        .status          (status),
        .data_in_latched (data_in_latched),
        .branch_cross    (branch_cross)
    );

endmodule

/* logic/cpu_datapath.sv */
`timescale 1ns/1ps

module cpu_datapath import cpu_pkg::*;
#(
    parameter logic [word_w-1:0] reset_vector = 16'hfffc
)
(
    input  logic              clock,
    input  logic              reset,
    input  logic              enable,
    input  logic [byte_w-1:0] data_in,
    input  control_t          control,
    output logic [word_w-1:0] address,
    output logic [byte_w-1:0] data_out,
    output logic              write_enable,
    output status_t           status,
    output logic [byte_w-1:0] data_in_latched,
    output logic              branch_cross
);

    retire_t           retire;
    logic [word_w-1:0] pc;
    logic [word_w-1:0] pc_plus;
    logic [word_w-1:0] pc_next;
    logic [byte_w-1:0] reg_a;
    logic [byte_w-1:0] reg_x;
    logic [byte_w-1:0] reg_y;
    status_t           flags;
    logic [byte_w-1:0] data_latch; // Byte read last cycle
    logic [byte_w-1:0] data_prev;  // Byte before that
    logic [byte_w:0]   branch_sum;
    logic [byte_w:0]   branch_reg; // Target low byte with carry
    logic [byte_w-1:0] alu_a;
    logic [byte_w-1:0] alu_result;
    logic              alu_carry;
    logic              alu_overflow;
    logic              alu_carry_in;
    logic [byte_w-1:0] count_in;
    logic [byte_w-1:0] count_out;
    logic [byte_w-1:0] bus;

    assign retire = control.retire;

    assign alu_a        = retire.cmp_index ? (retire.cmp_x ? reg_x : reg_y) : reg_a;
    assign alu_carry_in = (retire.alu_op == op_cmp) | flags.c; // Compare has no borrow in

    cpu_alu alu (
        .a         (alu_a),
        .b         (data_latch),
        .carry_in  (alu_carry_in),
        .op        (retire.alu_op),
        .result    (alu_result),
        .carry_out (alu_carry),
        .overflow  (alu_overflow)
    );

    // Transfers pass through with no count
    assign count_in  = retire.count_x ? reg_x : reg_y;
    assign count_out = count_in + {byte_w{retire.count_dec}} + byte_w'(retire.count_inc);

    always_comb
    begin
        case (retire.bus_src)
            bus_data:  bus = data_latch;
            bus_alu:   bus = alu_result;
            bus_count: bus = count_out;
            default:   bus = reg_a;
        endcase
    end

    assign pc_plus    = pc + 1'b1;
    // Offset is on data_in in st_operand, base is the byte after it
    assign branch_sum = {1'b0, pc_plus[byte_w-1:0]} + {1'b0, data_in};

    always_comb
    begin
        if (control.pc_load)
            pc_next = {data_in, data_latch};
        else if (control.pc_branch_low)
            pc_next = {pc[word_w-1:byte_w], branch_reg[byte_w-1:0]};
        else if (control.pc_branch_fix)
            pc_next = {pc[word_w-1:byte_w] + (branch_reg[byte_w] ? 8'h01 : 8'hff),
                       pc[byte_w-1:0]}; // Carry forward, else borrow
        else if (control.pc_inc)
            pc_next = pc_plus;
        else
            pc_next = pc;
    end

    assign address = ({word_w{control.addr_pc}}   & pc)
                   | ({word_w{control.addr_zero}} & {{byte_w{1'b0}}, data_latch})
                   | ({word_w{control.addr_abs}}  & {data_latch, data_prev});

    always_comb
    begin
        case (control.store_sel)
            2'b00:   data_out = reg_y;
            2'b10:   data_out = reg_x;
            default: data_out = reg_a;
        endcase
    end

    assign write_enable    = control.write;
    assign status          = flags;
    assign data_in_latched = data_latch;
    assign branch_cross    = branch_reg[byte_w];

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            pc    <= reset_vector;
            flags <= '0;
        end
        else if (enable)
        begin
            pc <= pc_next;
            if (retire.update_nz)
            begin
                flags.n <= bus[byte_w-1];
                flags.z <= bus == '0;
            end
            if (retire.c_opcode)
                flags.c <= retire.c_value;
            else if (retire.c_alu)
                flags.c <= alu_carry;
            if (retire.v_clear)
                flags.v <= 1'b0;
            else if (retire.v_alu)
                flags.v <= alu_overflow;
        end
    end

    always_ff @(posedge clock)
    begin
        if (enable)
        begin
            data_latch <= data_in;
            data_prev  <= data_latch;
            if (!control.pc_branch_low && !control.pc_branch_fix)
                branch_reg <= branch_sum; // Held through both branch cycles
            if (retire.load_a)
                reg_a <= bus;
            if (retire.load_x)
                reg_x <= bus;
            if (retire.load_y)
                reg_y <= bus;
        end
    end

endmodule

/* logic/cpu_alu.sv */
`timescale 1ns/1ps

module cpu_alu import cpu_pkg::*;
(
    input  logic [byte_w-1:0] a,
    input  logic [byte_w-1:0] b,
    input  logic              carry_in,
    input  alu_op_e           op,
    output logic [byte_w-1:0] result,
    output logic              carry_out,
    output logic              overflow
);

    logic [byte_w-1:0] b_operand;
    logic [byte_w-1:0] sum;

    // Subtract as add of the complement
    assign b_operand = (op == op_cmp || op == op_sbc) ? ~b : b;

    assign {carry_out, sum} = {1'b0, a} + {1'b0, b_operand} + (byte_w + 1)'(carry_in);

    // Same operand signs but the sum differs
    assign overflow = (a[byte_w-1] == b_operand[byte_w-1]) && (sum[byte_w-1] != a[byte_w-1]);

    always_comb
    begin
        case (op)
            op_ora:  result = a | b;
            op_and:  result = a & b;
            op_eor:  result = a ^ b;
            default: result = sum; // ADC SBC CMP
        endcase
    end

endmodule

/* logic/cpu_sequencer.sv */
`timescale 1ns/1ps

module cpu_sequencer import cpu_pkg::*;
(
    input  logic              clock,
    input  logic              reset,
    input  logic              enable,
    input  logic [byte_w-1:0] data_in,
    input  status_t           status,
    input  logic [byte_w-1:0] data_in_latched,
    input  logic              branch_cross,
    output control_t          control,
    output logic              sync
);

    cpu_state_e        state;
    cpu_state_e        next_state;
    logic [byte_w-1:0] opcode;
    decode_t           decode;
    logic [3:0]        branch_flags;
    logic              branch_taken;
    logic              page_cross;

    cpu_decoder decoder (
        .opcode (opcode),
        .decode (decode)
    );

    // BPL BMI, BVC BVS, BCC BCS, BNE BEQ
    assign branch_flags = {status.z, status.c, status.v, status.n};
    assign branch_taken = branch_flags[opcode[7:6]] == opcode[5];
    // Offset still in the latch, a negative one inverts the carry
    assign page_cross   = branch_cross ^ data_in_latched[7];
    assign sync         = state == st_fetch;

    always_comb
    begin
        control    = '0;
        next_state = st_fetch;
        case (state)
            st_fetch:
            begin
                control.addr_pc = 1'b1;
                control.pc_inc  = 1'b1;
                control.retire  = decode.retire; // Opcode reg still holds the last instruction
                next_state      = st_operand;
            end
            st_operand:
            begin
                control.addr_pc = 1'b1;
                control.pc_inc  = decode.mode != mode_implied; // Dummy read for implied
                case (decode.mode)
                    mode_zero_page:           next_state = st_zero_page;
                    mode_absolute, mode_jump: next_state = st_addr_high;
                    mode_relative:            next_state = branch_taken ? st_branch_low : st_fetch;
                    default:                  next_state = st_fetch;
                endcase
            end
            st_addr_high:
            begin
                control.addr_pc = 1'b1;
                control.pc_load = decode.mode == mode_jump; // JMP ends here
                control.pc_inc  = decode.mode != mode_jump;
                next_state      = (decode.mode == mode_jump) ? st_fetch : st_absolute;
            end
            st_zero_page, st_absolute:
            begin
                control.addr_zero = state == st_zero_page;
                control.addr_abs  = state == st_absolute;
                control.write     = decode.store; // Stores write in the last cycle
                control.store_sel = decode.store_sel;
            end
            st_branch_low:
            begin
                control.addr_pc       = 1'b1;
                control.pc_branch_low = 1'b1;
                next_state            = page_cross ? st_branch_fix : st_fetch;
            end
            st_branch_fix:
            begin
                control.addr_pc       = 1'b1;
                control.pc_branch_fix = 1'b1;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            state  <= st_operand;   // Vector read through a JMP
            opcode <= reset_opcode;
        end
        else if (enable)
        begin
            state <= next_state;
            if (state == st_fetch)
                opcode <= data_in;
        end
    end

endmodule

/* logic/cpu_decoder.sv */
`timescale 1ns/1ps

module cpu_decoder import cpu_pkg::*;
(
    input  logic [byte_w-1:0] opcode,
    output decode_t           decode
);

    logic [2:0] bbb;       // Addressing field
    logic [1:0] cc;        // Group field
    logic       mem_form;  // Zero page or absolute
    logic       group_one;
    logic       group_xy;  // LDX LDY STX STY CPX CPY
    logic       use_x;
    addr_mode_e operand_mode;

    assign bbb      = opcode[4:2];
    assign cc       = opcode[1:0];
    assign mem_form = (bbb == 3'b001) || (bbb == 3'b011);
    assign operand_mode = (bbb == 3'b001) ? mode_zero_page :
                          (bbb == 3'b011) ? mode_absolute : mode_immediate;

    // No STA immediate
    assign group_one = (cc == 2'b01) && (mem_form || bbb == 3'b010) && (opcode != 8'h89);
    // Immediate form only for loads and compares
    assign group_xy  = opcode[7] && (cc == 2'b00 || (cc == 2'b10 && !opcode[6]))
                       && (mem_form || (bbb == 3'b000 && opcode[6:5] != 2'b00));
    assign use_x     = opcode[1] || (opcode[7:5] == 3'b111); // CPX is in the Y column

    always_comb
    begin
        decode = '0; // Unknown opcodes stay implied with no effect
        if (group_one)
        begin
            decode.mode             = operand_mode;
            decode.retire.alu_op    = alu_op_e'(opcode[7:5]);
            decode.retire.update_nz = opcode[7:5] != 3'b100;
            decode.retire.bus_src   = bus_alu;
            case (alu_op_e'(opcode[7:5]))
                op_sta:
                begin
                    decode.store     = 1'b1;
                    decode.store_sel = cc;
                end
                op_lda:
                begin
                    decode.retire.bus_src = bus_data;
                    decode.retire.load_a  = 1'b1;
                end
                op_cmp: decode.retire.c_alu = 1'b1;
                default:
                begin
                    decode.retire.load_a = 1'b1;
                    decode.retire.c_alu  = opcode[6:5] == 2'b11; // ADC and SBC
                    decode.retire.v_alu  = opcode[6:5] == 2'b11;
                end
            endcase
        end
        else if (group_xy)
        begin
            decode.mode = operand_mode;
            case (opcode[7:5])
                3'b100:
                begin
                    decode.store     = 1'b1;
                    decode.store_sel = cc; // Same coding as STA
                end
                3'b101:
                begin
                    decode.retire.bus_src   = bus_data;
                    decode.retire.load_x    = use_x;
                    decode.retire.load_y    = !use_x;
                    decode.retire.update_nz = 1'b1;
                end
                default:
                begin
                    decode.retire.alu_op    = op_cmp;
                    decode.retire.cmp_index = 1'b1;
                    decode.retire.cmp_x     = use_x;
                    decode.retire.bus_src   = bus_alu;
                    decode.retire.update_nz = 1'b1;
                    decode.retire.c_alu     = 1'b1;
                end
            endcase
        end
        else if (opcode ==? branch_opcode_mask)
            decode.mode = mode_relative;
        else
        begin
            case (opcode)
                8'haa, 8'ha8: // TAX TAY
                begin
                    decode.retire.bus_src = bus_a;
                    decode.retire.load_x  = opcode[1];
                    decode.retire.load_y  = !opcode[1];
                end
                8'h8a, 8'h98: // TXA TYA
                begin
                    decode.retire.bus_src = bus_count;
                    decode.retire.count_x = opcode[1];
                    decode.retire.load_a  = 1'b1;
                end
                8'he8, 8'hc8, 8'hca, 8'h88: // INX INY DEX DEY
                begin
                    decode.retire.bus_src   = bus_count;
                    decode.retire.count_x   = (opcode == 8'he8) || (opcode == 8'hca);
                    decode.retire.count_inc = opcode[6] && !opcode[1];
                    decode.retire.count_dec = !opcode[6] || opcode[1];
                    decode.retire.load_x    = (opcode == 8'he8) || (opcode == 8'hca);
                    decode.retire.load_y    = (opcode == 8'hc8) || (opcode == 8'h88);
                end
                8'h18, 8'h38:
                begin
                    decode.retire.c_opcode = 1'b1;
                    decode.retire.c_value  = opcode[5];
                end
                8'hb8: decode.retire.v_clear = 1'b1;
                8'h4c: decode.mode = mode_jump;
                default: ;
            endcase
            // Every register op above sets N and Z
            decode.retire.update_nz = decode.retire.load_a | decode.retire.load_x
                                      | decode.retire.load_y;
        end
    end

endmodule

/* logic/cpu_pkg.sv */
package cpu_pkg;

    localparam int word_w = 16; // Address width
    localparam int byte_w = 8;  // Data width

    localparam logic [byte_w-1:0] reset_opcode       = 8'h4c;       // JMP absolute
    localparam logic [byte_w-1:0] branch_opcode_mask = 8'b???1_0000; // Bxx rel, use with ==?

    // Bus cycle of the current instruction
    typedef enum logic [2:0] {
        st_fetch,      // Opcode read, previous instruction retires
        st_operand,    // First byte after opcode
        st_addr_high,  // High byte of absolute address
        st_zero_page,  // Access at 00:operand
        st_absolute,   // Access at 16-bit operand
        st_branch_low, // PCL gets branch target
        st_branch_fix  // PCH fixup on page cross
    } cpu_state_e;

    // Group one operation, opcode bits 7:5
    typedef enum logic [2:0] {
        op_ora, op_and, op_eor, op_adc, op_sta, op_lda, op_cmp, op_sbc
    } alu_op_e;

    typedef enum logic [2:0] {
        mode_implied, mode_immediate, mode_zero_page, mode_absolute, mode_relative, mode_jump
    } addr_mode_e;

    // Internal bus drivers
    typedef enum logic [1:0] {bus_data, bus_alu, bus_count, bus_a} bus_src_e;

    typedef struct packed {
        logic n;
        logic v;
        logic z;
        logic c;
    } status_t;

    // Register and flag work done in the fetch cycle after the instruction
    typedef struct packed {
        alu_op_e  alu_op;
        logic     cmp_index; // Compare operand is X or Y, not A
        logic     cmp_x;     // X rather than Y
        bus_src_e bus_src;
        logic     load_a;
        logic     load_x;
        logic     load_y;
        logic     count_x;   // Counter input X, else Y
        logic     count_inc;
        logic     count_dec;
        logic     update_nz; // N and Z from bus
        logic     c_alu;
        logic     v_alu;
        logic     c_opcode;  // CLC or SEC
        logic     c_value;   // Opcode bit 5
        logic     v_clear;
    } retire_t;

    typedef struct packed {
        addr_mode_e mode;
        logic       store;
        logic [1:0] store_sel; // 00 Y, 01 A, 10 X
        retire_t    retire;
    } decode_t;

    typedef struct packed {
        logic       addr_pc;
        logic       addr_zero;
        logic       addr_abs;
        logic       pc_inc;
        logic       pc_load;       // PC from data_in and latch
        logic       pc_branch_low;
        logic       pc_branch_fix;
        logic       write;
        logic [1:0] store_sel;
        retire_t    retire;
    } control_t;

endpackage
